/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_flash_writer
LINT_TOP  ?= flash_writer_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
rtl/flash_pkg.sv
rtl/byte_shift_if.sv
rtl/spi_byte_shifter.sv
rtl/page_word_fifo.sv
rtl/flash_page_writer.sv
rtl/flash_writer_top.sv
verification/flash_spi_monitor.sv
verification/tb_flash_writer.sv

/* rtl/byte_shift_if.sv */
`timescale 1ns/1ps

// byte handoff from the sequencer to the SPI shifter
interface byte_shift_if;
   import flash_pkg::*;

   logic      valid;  // sequencer has a byte
   logic      ready;  // shifter can take it
   spi_byte_t data;
   logic      done;   // last bit of a byte has gone out

   modport sequencer (
      output valid,
      output data,
      input  ready,
      input  done
   );

   modport shifter (
      input  valid,
      input  data,
      output ready,
      output done
   );

endinterface

/* rtl/flash_page_writer.sv */
`timescale 1ns/1ps

module flash_page_writer #(
   parameter int WORDS_PER_PAGE = 128,
   parameter int WAIT_CYCLES    = 1024
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   cmd_valid,
   output logic                   cmd_ready,
   input  flash_pkg::flash_addr_t cmd_addr,
   input  flash_pkg::page_count_t cmd_pages,
   input  logic                   word_valid,
   output logic                   word_ready,
   input  flash_pkg::data_word_t  word,
   byte_shift_if.sequencer        shift,
   output logic                   cs_n,
   output logic                   busy
);
   import flash_pkg::*;

   localparam int WCW = (WORDS_PER_PAGE > 1) ? $clog2(WORDS_PER_PAGE) : 1;
   localparam int WTW = (WAIT_CYCLES > 1) ? $clog2(WAIT_CYCLES) : 1;

   writer_state_t  state;
   writer_state_t  state_next;
   flash_addr_t    addr_reg;    // start of the page being programmed
   page_count_t    pages_left;
   logic [1:0]     addr_idx;    // which address byte is next
   logic [WCW-1:0] word_cnt;
   logic [WTW-1:0] wait_cnt;
   logic           low_half;    // high byte of the word already handed over
   logic           last_sent;   // frame's final byte is with the shifter
   logic           in_wait;
   logic           wait_done;
   logic           frame_end;
   logic           hs;
   logic           byte_valid;
   spi_byte_t      byte_data;

   assign shift.valid = byte_valid;
   assign shift.data  = byte_data;
   assign hs          = byte_valid && shift.ready;
   assign frame_end   = shift.done && last_sent;

   assign cmd_ready  = (state == IDLE);
   assign busy       = (state != IDLE);
   assign in_wait    = state inside {WAKE_WAIT, WE_WAIT, BANK_WAIT};
   assign wait_done  = in_wait && (wait_cnt == WTW'(WAIT_CYCLES - 1));
   assign word_ready = (state == PP_DATA) && hs && low_half;  // pop after the low byte

   always_comb begin
      byte_valid = 1'b0;
      byte_data  = CMD_WAKE_UP;
      case (state)
         WAKE_CMD: begin
            byte_valid = !last_sent;
            byte_data  = CMD_WAKE_UP;
         end
         WE_CMD: begin
            byte_valid = !last_sent;
            byte_data  = CMD_WRITE_ENABLE;
         end
         PP_CMD: begin
            byte_valid = 1'b1;
            byte_data  = CMD_PAGE_PROGRAM;
         end
         PP_ADDR: begin
            byte_valid = 1'b1;
            case (addr_idx)
               2'd0:    byte_data = addr_reg[23:16];
               2'd1:    byte_data = addr_reg[15:8];
               default: byte_data = addr_reg[7:0];
            endcase
         end
         PP_DATA: begin
            // empty FIFO holds valid low, the frame just stretches
            byte_valid = word_valid && !last_sent;
            byte_data  = low_half ? word[7:0] : word[15:8];
         end
         default: begin
            byte_valid = 1'b0;
         end
      endcase
   end

   always_comb begin
      state_next = state;
      case (state)
         IDLE:      if (cmd_valid && (cmd_pages != '0)) state_next = WAKE_CMD;
         WAKE_CMD:  if (frame_end) state_next = WAKE_WAIT;
         WAKE_WAIT: if (wait_done) state_next = WE_CMD;
         WE_CMD:    if (frame_end) state_next = WE_WAIT;
         WE_WAIT:   if (wait_done) state_next = PP_CMD;
         PP_CMD:    if (hs) state_next = PP_ADDR;
         PP_ADDR:   if (hs && (addr_idx == 2'd2)) state_next = PP_DATA;
         PP_DATA:   if (frame_end) state_next = BANK_WAIT;
         BANK_WAIT: if (wait_done) state_next = (pages_left == '0) ? IDLE : WAKE_CMD;
         default:   state_next = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= IDLE;
         cs_n       <= 1'b1;
         pages_left <= '0;
         addr_idx   <= '0;
         word_cnt   <= '0;
         wait_cnt   <= '0;
         low_half   <= 1'b0;
         last_sent  <= 1'b0;
      end else begin
         state    <= state_next;
         if (frame_end) begin
            cs_n <= 1'b1;  // deselect once the frame's last byte has drained
         end else if (state_next inside {WAKE_CMD, WE_CMD, PP_CMD}) begin
            cs_n <= 1'b0;  // select opens with the frame's opcode
         end
         wait_cnt <= (in_wait && !wait_done) ? wait_cnt + 1'b1 : '0;
         case (state)
            IDLE: begin
               if (cmd_valid) begin
                  pages_left <= cmd_pages;
               end
            end
            WAKE_CMD, WE_CMD: begin  // single byte frames
               if (hs) begin
                  last_sent <= 1'b1;
               end else if (frame_end) begin
                  last_sent <= 1'b0;
               end
            end
            PP_CMD: addr_idx <= '0;
            PP_ADDR: begin
               if (hs) begin
                  addr_idx <= addr_idx + 1'b1;
               end
            end
            PP_DATA: begin
               if (hs) begin
                  low_half <= !low_half;
                  if (low_half && (word_cnt == WCW'(WORDS_PER_PAGE - 1))) begin
                     word_cnt  <= '0;
                     last_sent <= 1'b1;  // page is complete once this byte drains
                  end else if (low_half) begin
                     word_cnt <= word_cnt + 1'b1;
                  end
               end else if (frame_end) begin
                  last_sent  <= 1'b0;
                  pages_left <= pages_left - 1'b1;
               end
            end
            default: begin
               last_sent <= 1'b0;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((state == IDLE) && cmd_valid) begin
         addr_reg <= cmd_addr;
      end else if ((state == PP_DATA) && frame_end) begin
         addr_reg <= addr_reg + flash_addr_t'(2 * WORDS_PER_PAGE);  // next page
      end
   end

   a_cs_quiet: assert property (@(posedge clk) disable iff (reset)
      (state inside {IDLE, WAKE_WAIT, WE_WAIT, BANK_WAIT}) |-> cs_n);

endmodule

/* rtl/flash_pkg.sv */
package flash_pkg;

   // widths that carry a meaning across the design
   typedef logic [23:0] flash_addr_t;  // flash byte address
   typedef logic [15:0] data_word_t;   // host data word
   typedef logic [7:0]  page_count_t;  // pages per job, zero is a no-op
   typedef logic [7:0]  spi_byte_t;    // one byte on the wire

   // flash opcodes
   localparam spi_byte_t CMD_WAKE_UP      = 8'hAB;  // release from deep power-down
   localparam spi_byte_t CMD_WRITE_ENABLE = 8'h06;
   localparam spi_byte_t CMD_PAGE_PROGRAM = 8'h02;

   // sequencer states, one pass per page
   typedef enum logic [3:0] {
      IDLE,
      WAKE_CMD,
      WAKE_WAIT,
      WE_CMD,
      WE_WAIT,
      PP_CMD,
      PP_ADDR,
      PP_DATA,
      BANK_WAIT
   } writer_state_t;

endpackage

/* rtl/flash_writer_top.sv */
`timescale 1ns/1ps

module flash_writer_top #(
   parameter int SCK_HALF       = 4,
   parameter int WORDS_PER_PAGE = 128,
   parameter int WAIT_CYCLES    = 1024,
   parameter int FIFO_DEPTH     = 4
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   cmd_valid,
   output logic                   cmd_ready,
   input  flash_pkg::flash_addr_t cmd_addr,
   input  flash_pkg::page_count_t cmd_pages,
   input  logic                   data_valid,
   output logic                   data_ready,
   input  flash_pkg::data_word_t  data_word,
   output logic                   busy,
   output logic                   spi_sck,
   output logic                   spi_cs_n,
   output logic                   spi_mosi
);
   import flash_pkg::*;

   logic       word_valid;  // FIFO head to sequencer
   logic       word_ready;
   data_word_t word;

   byte_shift_if byte_if ();

   page_word_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) fifo_i (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (data_valid),
      .in_ready  (data_ready),
      .in_word   (data_word),
      .out_valid (word_valid),
      .out_ready (word_ready),
      .out_word  (word)
   );

   flash_page_writer #(
      .WORDS_PER_PAGE (WORDS_PER_PAGE),
      .WAIT_CYCLES    (WAIT_CYCLES)
   ) writer_i (
      .clk        (clk),
      .reset      (reset),
      .cmd_valid  (cmd_valid),
      .cmd_ready  (cmd_ready),
      .cmd_addr   (cmd_addr),
      .cmd_pages  (cmd_pages),
      .word_valid (word_valid),
      .word_ready (word_ready),
      .word       (word),
      .shift      (byte_if.sequencer),
      .cs_n       (spi_cs_n),
      .busy       (busy)
   );

   spi_byte_shifter #(
      .SCK_HALF (SCK_HALF)
   ) shifter_i (
      .clk   (clk),
      .reset (reset),
      .shift (byte_if.shifter),
      .sck   (spi_sck),
      .mosi  (spi_mosi)
   );

endmodule

/* rtl/page_word_fifo.sv */
`timescale 1ns/1ps

module page_word_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  in_valid,
   output logic                  in_ready,
   input  flash_pkg::data_word_t in_word,
   output logic                  out_valid,
   input  logic                  out_ready,
   output flash_pkg::data_word_t out_word
);
   import flash_pkg::*;

   localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CW = $clog2(FIFO_DEPTH + 1);

   data_word_t    mem [FIFO_DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic          push;
   logic          pop;

   function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
      return (p == AW'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;  // wraps for any depth
   endfunction

   assign out_valid = (count != '0);
   assign in_ready  = (count != CW'(FIFO_DEPTH)) || out_ready;  // full but draining
   assign out_word  = mem[rd_ptr];
   assign push      = in_valid && in_ready;
   assign pop       = out_valid && out_ready;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_word;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // both or neither
         endcase
      end
   end

   // a lone push or pop keeps the count within depth
   a_count_bounds: assert property (@(posedge clk) disable iff (reset)
      (push ^ pop) |=> (count <= CW'(FIFO_DEPTH)));

endmodule

/* rtl/spi_byte_shifter.sv */
`timescale 1ns/1ps

module spi_byte_shifter #(
   parameter int SCK_HALF = 4
) (
   input  logic          clk,
   input  logic          reset,
   byte_shift_if.shifter shift,
   output logic          sck,
   output logic          mosi
);
   import flash_pkg::*;

   localparam int PW = $clog2(2 * SCK_HALF);

   logic          active;    // a byte is on the wire
   logic [PW-1:0] phase;     // position inside the current bit
   logic [2:0]    bit_cnt;
   spi_byte_t     shreg;     // bit 7 is the bit being driven
   logic          bit_end;
   logic          last_cycle;
   logic          take;

   assign bit_end    = (phase == PW'(2 * SCK_HALF - 1));
   assign last_cycle = active && bit_end && (bit_cnt == 3'd7);

   // next byte may be taken in the final cycle so bytes run back to back
   assign shift.ready = !active || last_cycle;
   assign shift.done  = last_cycle;
   assign take        = shift.valid && shift.ready;

   assign mosi = shreg[7];  // msb first

   always_ff @(posedge clk) begin
      if (reset) begin
         active  <= 1'b0;
         phase   <= '0;
         bit_cnt <= '0;
         sck     <= 1'b0;
         shreg   <= '0;
      end else if (take) begin
         active  <= 1'b1;
         phase   <= '0;
         bit_cnt <= '0;
         sck     <= 1'b0;           // low phase of bit 7 starts next cycle
         shreg   <= shift.data;
      end else if (last_cycle) begin
         active <= 1'b0;
         sck    <= 1'b0;
         shreg  <= '0;              // mosi parks low between bytes
      end else if (active) begin
         if (bit_end) begin
            phase   <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            sck     <= 1'b0;        // mode 0, data changes while sck is low
            shreg   <= {shreg[6:0], 1'b0};
         end else begin
            phase <= phase + 1'b1;
            if (phase == PW'(SCK_HALF - 1)) begin
               sck <= 1'b1;         // rising edge at mid bit, flash samples here
            end
         end
      end
   end

   // a stalled byte must not change under the shifter
   a_data_hold: assert property (@(posedge clk) disable iff (reset)
      shift.valid && !shift.ready |=> $stable(shift.data));

endmodule

/* verification/flash_spi_monitor.sv */
`timescale 1ns/1ps

// passive flash-side model, latches mosi on rising sck as a mode 0 device does
module flash_spi_monitor (
   input  logic sck,
   input  logic cs_n,
   input  logic mosi,
   output int   frame_count,    // frames closed so far
   output int   broken_frames   // frames that closed in the middle of a byte
);
   import flash_pkg::*;

   spi_byte_t frame_bytes[$];   // every frame's bytes, back to back
   int        frame_len[$];     // byte count of each frame
   spi_byte_t shreg;
   int        bit_cnt;
   int        byte_cnt;

   initial begin
      frame_count   = 0;
      broken_frames = 0;
      shreg         = '0;
      bit_cnt       = 0;
      byte_cnt      = 0;
   end

   always @(posedge sck or posedge cs_n) begin
      if (cs_n) begin
         // deselect ends the frame
         if (bit_cnt != 0) begin
            broken_frames = broken_frames + 1;
         end
         if (byte_cnt != 0) begin
            frame_len.push_back(byte_cnt);
            frame_count = frame_count + 1;  // after the push, readers see a whole frame
         end
         bit_cnt  = 0;
         byte_cnt = 0;
      end else begin
         shreg   = {shreg[6:0], mosi};  // msb arrives first
         bit_cnt = bit_cnt + 1;
         if (bit_cnt == 8) begin
            frame_bytes.push_back(shreg);
            byte_cnt = byte_cnt + 1;
            bit_cnt  = 0;
         end
      end
   end

endmodule

/* verification/tb_flash_writer.sv */
`timescale 1ns/1ps

module tb_flash_writer;
   import flash_pkg::*;

   localparam int SCK_HALF       = 2;
   localparam int WORDS_PER_PAGE = 4;
   localparam int WAIT_CYCLES    = 16;
   localparam int FIFO_DEPTH     = 4;
   localparam int NUM_JOBS       = 5;
   localparam int MAX_PAGES      = 3;
   localparam int LONG_GAP       = 600;  // outlasts the first page's buffered words
   localparam int MAX_GAP        = 40;
   // two single byte frames and one page frame, three waits, host gaps
   localparam int PAGE_WORST = (2 + 4 + 2 * WORDS_PER_PAGE) * 16 * SCK_HALF
                               + 3 * WAIT_CYCLES + WORDS_PER_PAGE * (MAX_GAP + 2) + 64;
   localparam int TIMEOUT_CYCLES = NUM_JOBS * MAX_PAGES * PAGE_WORST + LONG_GAP + 500;

   logic        clk = 1'b0;
   logic        reset;
   logic        cmd_valid;
   logic        cmd_ready;
   flash_addr_t cmd_addr;
   page_count_t cmd_pages;
   logic        data_valid;
   logic        data_ready;
   data_word_t  data_word;
   logic        busy;
   logic        spi_sck;
   logic        spi_cs_n;
   logic        spi_mosi;
   int          frame_count;
   int          broken_frames;

   flash_addr_t job_addr [NUM_JOBS];
   page_count_t job_pages [NUM_JOBS];
   data_word_t  words[$];
   int          gaps[$];        // idle cycles before each word
   spi_byte_t   exp_bytes[$];
   int          exp_len[$];
   bit          exp_ready = 1'b0;
   int          errors = 0;
   int          faults = 0;
   int          cycles = 0;
   int          frames_checked = 0;
   int          accepted = 0;
   int          frames_due = 0;
   int          cs_high_run = 0;
   int          low_run = 0;
   int          max_low_run = 0;
   bit          job_open = 1'b0;  // a job has been accepted and is not yet over
   bit          full_seen = 1'b0;

   always #10 clk = ~clk;

   flash_writer_top #(
      .SCK_HALF       (SCK_HALF),
      .WORDS_PER_PAGE (WORDS_PER_PAGE),
      .WAIT_CYCLES    (WAIT_CYCLES),
      .FIFO_DEPTH     (FIFO_DEPTH)
   ) dut_i (
      .clk        (clk),
      .reset      (reset),
      .cmd_valid  (cmd_valid),
      .cmd_ready  (cmd_ready),
      .cmd_addr   (cmd_addr),
      .cmd_pages  (cmd_pages),
      .data_valid (data_valid),
      .data_ready (data_ready),
      .data_word  (data_word),
      .busy       (busy),
      .spi_sck    (spi_sck),
      .spi_cs_n   (spi_cs_n),
      .spi_mosi   (spi_mosi)
   );

   flash_spi_monitor mon_i (
      .sck           (spi_sck),
      .cs_n          (spi_cs_n),
      .mosi          (spi_mosi),
      .frame_count   (frame_count),
      .broken_frames (broken_frames)
   );

   task automatic check_value(input int got, input int expected, input string what);
      if (got != expected) begin
         errors++;
         $display("[ERROR] %0t: %s, got 0x%0h expected 0x%0h", $time, what, got, expected);
      end
   endtask

   // frames a flash device should see for one job
   function automatic void expect_job(input flash_addr_t base, input page_count_t pages,
                                      input int first);
      flash_addr_t a;
      data_word_t  w;
      for (int p = 0; p < int'(pages); p++) begin
         a = base + flash_addr_t'(2 * WORDS_PER_PAGE * p);  // pages sit back to back
         exp_bytes.push_back(8'hAB);  // wake-up
         exp_len.push_back(1);
         exp_bytes.push_back(8'h06);  // write enable
         exp_len.push_back(1);
         exp_bytes.push_back(8'h02);
         exp_bytes.push_back(a[23:16]);
         exp_bytes.push_back(a[15:8]);
         exp_bytes.push_back(a[7:0]);
         for (int k = 0; k < WORDS_PER_PAGE; k++) begin
            w = words[first + p * WORDS_PER_PAGE + k];
            exp_bytes.push_back(w[15:8]);  // high byte first
            exp_bytes.push_back(w[7:0]);
         end
         exp_len.push_back(4 + 2 * WORDS_PER_PAGE);
      end
   endfunction

   function automatic void build_jobs();
      int first;
      int r;
      for (int j = 0; j < NUM_JOBS; j++) begin
         job_addr[j]  = flash_addr_t'($urandom);
         job_pages[j] = (j == 0) ? page_count_t'(1) : page_count_t'(1 + $urandom % MAX_PAGES);
         first        = words.size();
         for (int k = 0; k < int'(job_pages[j]) * WORDS_PER_PAGE; k++) begin
            r = int'($urandom % 8);
            words.push_back(data_word_t'($urandom));
            if (words.size() == 3)
               gaps.push_back(LONG_GAP);  // forces an empty FIFO mid page
            else if (r == 0)
               gaps.push_back(10 + int'($urandom % (MAX_GAP - 9)));
            else if (r < 3)
               gaps.push_back(int'($urandom % 4));
            else
               gaps.push_back(0);
         end
         expect_job(job_addr[j], job_pages[j], first);
      end
   endfunction

   task automatic send_cmd(input flash_addr_t addr, input page_count_t pages);
      @(negedge clk);
      cmd_valid = 1'b1;
      cmd_addr  = addr;
      cmd_pages = pages;
      while (!cmd_ready) @(negedge clk);  // held off while a job runs
      @(negedge clk);
      cmd_valid = 1'b0;
   endtask

   task automatic send_jobs();
      for (int j = 0; j < NUM_JOBS; j++) begin
         send_cmd(job_addr[j], job_pages[j]);
      end
   endtask

   task automatic stream_words();
      @(negedge clk);
      foreach (words[i]) begin
         if (gaps[i] > 0) begin
            data_valid = 1'b0;
            repeat (gaps[i]) @(negedge clk);
         end
         data_valid = 1'b1;
         data_word  = words[i];
         while (!data_ready) @(negedge clk);
         @(negedge clk);  // taken on the rising edge just passed
      end
      data_valid = 1'b0;
   endtask

   initial begin : compare_frames
      int pos_exp;
      int pos_got;
      int got_len;
      pos_exp = 0;
      pos_got = 0;
      wait (exp_ready);
      for (int f = 0; f < exp_len.size(); f++) begin
         wait (frame_count > f);
         got_len = mon_i.frame_len[f];
         check_value(got_len, exp_len[f], $sformatf("frame %0d length", f));
         for (int b = 0; b < exp_len[f] && b < got_len; b++) begin
            check_value(int'(mon_i.frame_bytes[pos_got + b]), int'(exp_bytes[pos_exp + b]),
                        $sformatf("frame %0d byte %0d", f, b));
         end
         pos_exp += exp_len[f];
         pos_got += got_len;
         frames_checked = f + 1;
      end
   end

   // handshake and status rules, sampled on the edge the DUT sees
   always @(posedge clk) begin
      if (!reset) begin
         check_value(int'(busy), int'(job_open), "busy while a job runs");
         check_value(int'(cmd_ready), int'(!job_open), "cmd_ready while a job runs");
         if (job_open && !spi_cs_n && cs_high_run != 0) begin
            check_value(cs_high_run, WAIT_CYCLES, "wait before a frame");
         end
         cs_high_run = (job_open && spi_cs_n) ? cs_high_run + 1 : 0;
         low_run     = (!spi_cs_n && !spi_sck) ? low_run + 1 : 0;  // selected but idle
         if (low_run > max_low_run) begin
            max_low_run = low_run;
         end
         if (!data_ready) begin
            full_seen = 1'b1;
         end
         // job is over once its last frame is followed by a full bank wait
         if (job_open && frame_count == frames_due && cs_high_run == WAIT_CYCLES) begin
            job_open = 1'b0;
         end
         if (cmd_valid && cmd_ready && accepted < NUM_JOBS) begin
            job_open   = 1'b1;
            frames_due += 3 * int'(job_pages[accepted]);
            accepted++;
         end
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
         $display("*** FAILED ***");
         $finish;
      end
   end

   initial begin
      void'($urandom(32'h8633_3870));
      reset      = 1'b1;
      cmd_valid  = 1'b0;
      cmd_addr   = '0;
      cmd_pages  = '0;
      data_valid = 1'b0;
      data_word  = '0;
      build_jobs();
      exp_ready = 1'b1;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      check_value(int'(spi_cs_n), 1, "cs_n after reset");
      check_value(int'(spi_sck), 0, "sck after reset");
      check_value(int'(spi_mosi), 0, "mosi after reset");
      check_value(int'(busy), 0, "busy after reset");
      check_value(int'(cmd_ready), 1, "cmd_ready after reset");
      check_value(int'(data_ready), 1, "data_ready after reset");
      fork
         send_jobs();
         stream_words();
      join
      while (busy) @(negedge clk);
      repeat (20) @(negedge clk);
      if (frames_checked < exp_len.size()) begin
         faults++;
         $display("missing frames: only %0d of %0d expected frames arrived",
                  frames_checked, exp_len.size());
      end
      if (frame_count > exp_len.size()) begin
         faults++;
         $display("extra frames: %0d arrived but %0d were expected", frame_count, exp_len.size());
      end
      if (broken_frames != 0) begin
         faults++;
         $display("chip select rose in the middle of a byte %0d times", broken_frames);
      end
      if (!full_seen) begin
         faults++;
         $display("data_ready never went low, the FIFO never filled up");
      end
      if (max_low_run <= 4 * SCK_HALF) begin
         faults++;
         $display("no page program frame was stretched by an empty FIFO");
      end
      $display("summary: %0d value errors, %0d other failures", errors, faults);
      if (errors == 0 && faults == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule
